// ==== design/window_pkg.sv ====
package window_pkg;

	//////////////////////////////////////////////////
	// memory layout

	localparam int NBANK = 4;          // row r lives in bank r % NBANK
	localparam int PIX_PER_WORD = 16;

	typedef logic [7:0] pixel_t;
	typedef logic [PIX_PER_WORD*8-1:0] bank_word_t;  // pixel k at bits 8k+7:8k
	typedef logic [8:0] bank_addr_t;
	typedef logic [NBANK-1:0] bank_sel_t;
	typedef logic [1:0] bank_idx_t;
	typedef logic [3:0] byte_idx_t;
	typedef logic [7:0] coord_t;

	//////////////////////////////////////////////////
	// pipeline payloads

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_FIRST_ROW,
		ST_MID_ROW,
		ST_LAST_ROW
	} scan_state_t;

	typedef struct packed {
		coord_t      row;
		coord_t      col;
		scan_state_t state;
		logic        row_start;
		logic        frame_end;
	} scan_step_t;

	typedef struct packed {
		bank_idx_t bank_top;
		bank_idx_t bank_mid;
		bank_idx_t bank_bot;
		byte_idx_t byte_idx;
		logic      pad_top;
		logic      pad_bot;
		logic      pad_right;
		logic      row_start;
		logic      frame_end;
	} tap_t;

	typedef struct packed {
		bank_sel_t                    cs;
		bank_addr_t [NBANK-1:0]       addr;
	} bank_req_t;

	typedef bank_word_t [NBANK-1:0] bank_rsp_t;

	typedef struct packed {
		pixel_t top;
		pixel_t mid;
		pixel_t bot;
		logic   valid;
		logic   row_start;
		logic   frame_end;
	} column_t;

	typedef pixel_t [8:0] window_t;    // row major, 0 is top left

endpackage

// ==== design/frame_scanner.sv ====
`timescale 1ns/1ps

module frame_scanner #(
	parameter int ROWS = 8,
	parameter int COLS = 32
) (
	input  logic                   clk,
	input  logic                   rstn,
	input  logic                   start,
	output logic                   busy,
	output window_pkg::scan_step_t step,
	output logic                   step_valid
);

	window_pkg::scan_state_t state;
	window_pkg::scan_state_t state_next;
	window_pkg::coord_t      row;
	window_pkg::coord_t      col;
	logic                    pad_step;
	logic                    last_row;
	logic                    next_last;

	assign pad_step = (col == window_pkg::coord_t'(COLS));  // one past the last pixel
	assign last_row = (row == window_pkg::coord_t'(ROWS - 1));
	assign next_last = (row == window_pkg::coord_t'(ROWS - 2));
	assign busy = (state != window_pkg::ST_IDLE);

	//////////////////////////////////////////////////
	// scan FSM

	always_comb begin
		state_next = state;
		case (state)
			window_pkg::ST_IDLE: begin
				if (start) state_next = window_pkg::ST_FIRST_ROW;
			end
			window_pkg::ST_FIRST_ROW: begin
				if (pad_step && last_row) state_next = window_pkg::ST_IDLE;  // single row map
				else if (pad_step && next_last) state_next = window_pkg::ST_LAST_ROW;
				else if (pad_step) state_next = window_pkg::ST_MID_ROW;
			end
			window_pkg::ST_MID_ROW: begin
				if (pad_step && next_last) state_next = window_pkg::ST_LAST_ROW;
			end
			window_pkg::ST_LAST_ROW: begin
				if (pad_step) state_next = window_pkg::ST_IDLE;
			end
			default: state_next = window_pkg::ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state <= window_pkg::ST_IDLE;
			row <= '0;
			col <= '0;
			step_valid <= 1'b0;
		end else begin
			state <= state_next;
			step_valid <= (state_next != window_pkg::ST_IDLE);
			if (!busy || pad_step) col <= '0;
			else col <= col + 1'b1;
			if (!busy || (pad_step && last_row)) row <= '0;
			else if (pad_step) row <= row + 1'b1;
		end
	end

	always_comb begin
		step.row = row;
		step.col = col;
		step.state = state;
		step.row_start = (col == '0);
		step.frame_end = pad_step && last_row;
	end

	a_no_step_in_idle: assert property (@(posedge clk) disable iff (!rstn)
		state == window_pkg::ST_IDLE |-> !step_valid);

endmodule

// ==== design/bank_addresser.sv ====
`timescale 1ns/1ps

module bank_addresser #(
	parameter int ROWS = 8,
	parameter int COLS = 32
) (
	input  logic                   clk,
	input  logic                   rstn,
	input  window_pkg::scan_step_t step,
	input  logic                   step_valid,
	output window_pkg::bank_req_t  req,
	output window_pkg::tap_t       tap,
	output logic                   tap_valid
);

	localparam int WORDS_PER_ROW = COLS / window_pkg::PIX_PER_WORD;

	window_pkg::coord_t                                 win_row [3];  // r-1, r, r+1
	logic [2:0]                                         row_in;
	logic                                               pad_right;
	window_pkg::bank_sel_t                              cs_d;
	window_pkg::bank_sel_t                              cs_q;
	window_pkg::bank_addr_t [window_pkg::NBANK-1:0]     addr_d;
	window_pkg::bank_addr_t [window_pkg::NBANK-1:0]     addr_q;
	window_pkg::tap_t                                   tap_d;

	function automatic window_pkg::bank_idx_t bank_of(input window_pkg::coord_t r);
		return window_pkg::bank_idx_t'(r % window_pkg::NBANK);
	endfunction

	function automatic window_pkg::bank_addr_t word_addr(input window_pkg::coord_t r,
			input window_pkg::coord_t c);
		int unsigned a;
		a = (r / window_pkg::NBANK) * WORDS_PER_ROW + c / window_pkg::PIX_PER_WORD;
		return window_pkg::bank_addr_t'(a);
	endfunction

	assign pad_right = (step.col == window_pkg::coord_t'(COLS));

	always_comb begin
		win_row[0] = step.row - 1'b1;
		win_row[1] = step.row;
		win_row[2] = step.row + 1'b1;
		row_in[0] = (step.state != window_pkg::ST_FIRST_ROW);
		row_in[1] = 1'b1;
		row_in[2] = (step.row != window_pkg::coord_t'(ROWS - 1));
		cs_d = '0;
		addr_d = '0;
		for (int k = 0; k < 3; k++) begin
			if (step_valid && row_in[k] && !pad_right) begin
				cs_d[bank_of(win_row[k])] = 1'b1;
				addr_d[bank_of(win_row[k])] = word_addr(win_row[k], step.col);
			end
		end
		tap_d.bank_top = bank_of(win_row[0]);
		tap_d.bank_mid = bank_of(win_row[1]);
		tap_d.bank_bot = bank_of(win_row[2]);
		tap_d.byte_idx = window_pkg::byte_idx_t'(step.col % window_pkg::PIX_PER_WORD);
		tap_d.pad_top = !row_in[0];
		tap_d.pad_bot = !row_in[2];
		tap_d.pad_right = pad_right;
		tap_d.row_start = step.row_start;
		tap_d.frame_end = step.frame_end;
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			cs_q <= '0;
			tap_valid <= 1'b0;
		end else begin
			cs_q <= cs_d;
			tap_valid <= step_valid;
		end
	end

	always_ff @(posedge clk) begin
		addr_q <= addr_d;
		tap <= tap_d;
	end

	always_comb begin
		req.cs = cs_q;
		req.addr = addr_q;
	end

	a_cs_max_three: assert property (@(posedge clk) disable iff (!rstn)
		$countones(req.cs) <= 3);

endmodule

// ==== design/pixel_slicer.sv ====
`timescale 1ns/1ps

module pixel_slicer (
	input  logic                  clk,
	input  logic                  rstn,
	input  window_pkg::tap_t      tap,
	input  logic                  tap_valid,
	input  window_pkg::bank_rsp_t rsp,
	output window_pkg::column_t   column
);

	window_pkg::tap_t   tap_q;        // lines up with bank data
	logic               tap_valid_q;
	logic               col_valid;
	window_pkg::pixel_t top_q;
	window_pkg::pixel_t mid_q;
	window_pkg::pixel_t bot_q;
	logic               row_start_q;
	logic               frame_end_q;

	function automatic window_pkg::pixel_t pick(input window_pkg::bank_word_t w,
			input window_pkg::byte_idx_t b, input logic pad);
		window_pkg::pixel_t p;
		p = w[8*b +: 8];
		return pad ? '0 : p;
	endfunction

	//////////////////////////////////////////////////
	// one byte per window row

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			tap_valid_q <= 1'b0;
			col_valid <= 1'b0;
		end else begin
			tap_valid_q <= tap_valid;
			col_valid <= tap_valid_q;
		end
	end

	always_ff @(posedge clk) begin
		tap_q <= tap;
		top_q <= pick(rsp[tap_q.bank_top], tap_q.byte_idx, tap_q.pad_top || tap_q.pad_right);
		mid_q <= pick(rsp[tap_q.bank_mid], tap_q.byte_idx, tap_q.pad_right);
		bot_q <= pick(rsp[tap_q.bank_bot], tap_q.byte_idx, tap_q.pad_bot || tap_q.pad_right);
		row_start_q <= tap_q.row_start;
		frame_end_q <= tap_q.frame_end;
	end

	always_comb begin
		column.top = top_q;
		column.mid = mid_q;
		column.bot = bot_q;
		column.valid = col_valid;
		column.row_start = row_start_q;
		column.frame_end = frame_end_q;
	end

endmodule

// ==== design/window_shifter.sv ====
`timescale 1ns/1ps

module window_shifter (
	input  logic                clk,
	input  logic                rstn,
	input  window_pkg::column_t column,
	output window_pkg::window_t window,
	output logic                window_valid,
	output logic                done
);

	window_pkg::pixel_t [2:0] left_q;     // index 0 is the top row
	window_pkg::pixel_t [2:0] centre_q;
	window_pkg::pixel_t [2:0] right;      // incoming column
	window_pkg::window_t      win_d;
	logic                     emit;
	logic                     frame_end_q;

	assign right = {column.bot, column.mid, column.top};
	assign emit = column.valid && !column.row_start;

	always_comb begin
		for (int k = 0; k < 3; k++) begin
			win_d[3*k] = left_q[k];
			win_d[3*k+1] = centre_q[k];
			win_d[3*k+2] = right[k];
		end
	end

	//////////////////////////////////////////////////
	// column shift

	always_ff @(posedge clk) begin
		if (column.valid) begin
			if (column.row_start) left_q <= '0;  // left pad
			else left_q <= centre_q;
			centre_q <= right;
		end
		if (emit) window <= win_d;
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			window_valid <= 1'b0;
			frame_end_q <= 1'b0;
			done <= 1'b0;
		end else begin
			window_valid <= emit;
			frame_end_q <= column.valid && column.frame_end;
			done <= frame_end_q;  // one after the last window
		end
	end

endmodule

// ==== design/conv_window_fetch.sv ====
`timescale 1ns/1ps

module conv_window_fetch #(
	parameter int ROWS = 8,
	parameter int COLS = 32
) (
	input  logic                  clk,
	input  logic                  rstn,
	input  logic                  start,
	output logic                  busy,
	output window_pkg::bank_req_t req,
	input  window_pkg::bank_rsp_t rsp,
	output window_pkg::window_t   window,
	output logic                  window_valid,
	output logic                  done
);

	window_pkg::scan_step_t step;
	logic                   step_valid;
	window_pkg::tap_t       tap;
	logic                   tap_valid;
	window_pkg::column_t    column;

	frame_scanner #(
		.ROWS (ROWS),
		.COLS (COLS)
	) u_frame_scanner (
		.clk        (clk),
		.rstn       (rstn),
		.start      (start),
		.busy       (busy),
		.step       (step),
		.step_valid (step_valid)
	);

	bank_addresser #(
		.ROWS (ROWS),
		.COLS (COLS)
	) u_bank_addresser (
		.clk        (clk),
		.rstn       (rstn),
		.step       (step),
		.step_valid (step_valid),
		.req        (req),
		.tap        (tap),
		.tap_valid  (tap_valid)
	);

	pixel_slicer u_pixel_slicer (
		.clk       (clk),
		.rstn      (rstn),
		.tap       (tap),
		.tap_valid (tap_valid),
		.rsp       (rsp),
		.column    (column)
	);

	window_shifter u_window_shifter (
		.clk          (clk),
		.rstn         (rstn),
		.column       (column),
		.window       (window),
		.window_valid (window_valid),
		.done         (done)
	);

endmodule

// ==== tests/bank_memory.sv ====
`timescale 1ns/1ps

module bank_memory #(
	parameter int DEPTH = 512
) (
	input  logic                  clk,
	input  window_pkg::bank_req_t req,
	output window_pkg::bank_rsp_t rsp
);

	window_pkg::bank_word_t mem [window_pkg::NBANK][DEPTH];

	initial begin
		rsp = '0;
	end

	//////////////////////////////////////////////////
	// registered read, data one cycle after cs

	always @(posedge clk) begin
		for (int b = 0; b < window_pkg::NBANK; b++) begin
			if (req.cs[b]) begin
				rsp[b] <= mem[b][req.addr[b]];  // unselected banks hold their word
			end
		end
	end

	// backdoor load of one pixel into a bank word
	task automatic write_pixel(
		input int                 bank,
		input int                 addr,
		input int                 idx,
		input window_pkg::pixel_t p
	);
		mem[bank][addr][8*idx +: 8] = p;
	endtask

endmodule

// ==== tests/tb_conv_window_fetch.sv ====
`timescale 1ns/1ps

module tb_conv_window_fetch;

	localparam int ROWS = 8;
	localparam int COLS = 32;
	localparam int NFRAMES = 2;
	localparam int RESET_CYCLES = 4;
	localparam logic [31:0] SEED = 32'd78960;
	localparam int FRAME_CYCLES = ROWS * (COLS + 1) + 10;
	localparam int LIMIT_CYCLES = NFRAMES * (FRAME_CYCLES + 30) + 50;

	logic                  clk;
	logic                  rstn;
	logic                  start;
	logic                  busy;
	window_pkg::bank_req_t req;
	window_pkg::bank_rsp_t rsp;
	window_pkg::window_t   window;
	logic                  window_valid;
	logic                  done;

	window_pkg::pixel_t img [ROWS][COLS];
	logic [31:0]        rng;
	logic               frame_open;  // between start pulse and done
	int                 frames_done;
	int                 frame_idx;

	conv_window_fetch #(
		.ROWS (ROWS),
		.COLS (COLS)
	) u_conv_window_fetch (
		.clk          (clk),
		.rstn         (rstn),
		.start        (start),
		.busy         (busy),
		.req          (req),
		.rsp          (rsp),
		.window       (window),
		.window_valid (window_valid),
		.done         (done)
	);

	bank_memory u_bank_memory (
		.clk (clk),
		.req (req),
		.rsp (rsp)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// helpers

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// zero outside the map
	function automatic window_pkg::window_t expected_window(input int r, input int c);
		window_pkg::window_t w;
		int rr;
		int cc;
		for (int dr = 0; dr < 3; dr++) begin
			for (int dc = 0; dc < 3; dc++) begin
				rr = r - 1 + dr;
				cc = c - 1 + dc;
				if (rr < 0 || rr >= ROWS || cc < 0 || cc >= COLS) w[3*dr+dc] = '0;
				else w[3*dr+dc] = img[rr][cc];
			end
		end
		return w;
	endfunction

	function automatic window_pkg::bank_sel_t expected_cs(input int r, input int c);
		window_pkg::bank_sel_t cs;
		cs = '0;
		if (c < COLS) begin  // pad step reads nothing
			cs[r % window_pkg::NBANK] = 1'b1;
			if (r > 0) cs[(r - 1) % window_pkg::NBANK] = 1'b1;
			if (r < ROWS - 1) cs[(r + 1) % window_pkg::NBANK] = 1'b1;
		end
		return cs;
	endfunction

	task automatic stop_run(input string line);
		$display("%s", line);
		$display("Test failed");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_window(input string name, input window_pkg::window_t exp,
			input window_pkg::window_t act);
		if (act !== exp) stop_run($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act !== exp) stop_run($sformatf("FAILED %s: expected %0d, actual %0d", name, exp, act));
	endtask

	task automatic check_bank_sel(input string name, input window_pkg::bank_sel_t exp,
			input window_pkg::bank_sel_t act);
		if (act !== exp) stop_run($sformatf("FAILED %s: expected %b, actual %b", name, exp, act));
	endtask

	// new random image into img and the banks
	task automatic fill_image();
		int bank;
		int addr;
		for (int r = 0; r < ROWS; r++) begin
			for (int c = 0; c < COLS; c++) begin
				rng = xorshift32(rng);
				img[r][c] = rng[7:0];
				bank = r % window_pkg::NBANK;
				addr = (r / window_pkg::NBANK) * (COLS / window_pkg::PIX_PER_WORD)
					+ c / window_pkg::PIX_PER_WORD;
				u_bank_memory.write_pixel(bank, addr, c % window_pkg::PIX_PER_WORD, img[r][c]);
			end
		end
	endtask

	//////////////////////////////////////////////////
	// window and done compare

	initial begin : compare
		int count;
		int exp_r;
		int exp_c;
		string kind;
		count = 0;
		exp_r = 0;
		exp_c = 0;
		forever begin
			@(negedge clk);
			if (window_valid === 1'b1) begin
				if (!frame_open) begin
					stop_run("window_valid was raised while no frame was running");
				end else if (count >= ROWS * COLS) begin
					stop_run("more windows than pixels arrived before done");
				end else begin
					kind = (exp_r == 0 || exp_r == ROWS - 1 || exp_c == 0 || exp_c == COLS - 1)
						? "border" : "interior";
					check_window($sformatf("frame %0d %s window (%0d,%0d)", frame_idx, kind,
						exp_r, exp_c), expected_window(exp_r, exp_c), window);
					count++;
					exp_c++;
					if (exp_c == COLS) begin
						exp_c = 0;
						exp_r++;
					end
				end
			end
			if (done === 1'b1) begin
				if (!frame_open) begin
					stop_run("done pulsed while no frame was running");
				end else begin
					check_count($sformatf("frame %0d windows before done", frame_idx),
						ROWS * COLS, count);
					count = 0;
					exp_r = 0;
					exp_c = 0;
					frame_open = 1'b0;
					frames_done++;
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// chip selects per frame step

	initial begin : cs_monitor
		int i;
		int r;
		int c;
		window_pkg::bank_sel_t cs_exp;
		forever begin
			@(negedge clk);
			if (rstn === 1'b1 && req.cs != '0) begin
				for (i = 0; i < ROWS * (COLS + 1); i++) begin
					if (i > 0) @(negedge clk);
					r = i / (COLS + 1);
					c = i % (COLS + 1);
					cs_exp = expected_cs(r, c);
					if (cs_exp != '0) begin
						check_count($sformatf("chip select bits row %0d", r),
							(r == 0 || r == ROWS - 1) ? 2 : 3, $countones(req.cs));
					end
					check_bank_sel($sformatf("chip select row %0d col %0d", r, c), cs_exp, req.cs);
				end
			end
		end
	end

	initial begin : watchdog
		repeat (LIMIT_CYCLES) @(posedge clk);
		stop_run($sformatf("timeout: frames did not finish within %0d cycles", LIMIT_CYCLES));
	end

	//////////////////////////////////////////////////
	// stimulus

	initial begin : stimulus
		rstn = 1'b0;
		start = 1'b0;
		frame_open = 1'b0;
		frames_done = 0;
		frame_idx = 0;
		rng = SEED;
		fill_image();
		repeat (RESET_CYCLES) @(negedge clk);
		check_bank_sel("cs in reset", '0, req.cs);
		if (window_valid !== 1'b0) stop_run("window_valid was not low during reset");
		if (done !== 1'b0) stop_run("done was not low during reset");
		@(posedge clk);
		rstn <= 1'b1;
		repeat (2) @(posedge clk);
		for (int f = 0; f < NFRAMES; f++) begin
			if (f > 0) fill_image();  // banks are idle between frames
			frame_idx = f;
			@(posedge clk);
			start <= 1'b1;
			frame_open = 1'b1;
			@(posedge clk);
			start <= 1'b0;
			repeat (COLS) @(posedge clk);
			start <= 1'b1;  // start during the frame is ignored
			@(posedge clk);
			start <= 1'b0;
			while (frames_done < f + 1) @(posedge clk);
			repeat (8) @(posedge clk);
			check_count($sformatf("frame %0d busy after done", f), 0, busy);
		end
		$display("Test completed successfully");
		$finish;
	end

endmodule

// ==== files.f ====
design/window_pkg.sv
design/frame_scanner.sv
design/bank_addresser.sv
design/pixel_slicer.sv
design/window_shifter.sv
design/conv_window_fetch.sv
tests/bank_memory.sv
tests/tb_conv_window_fetch.sv

// ==== Bender.yml ====
package:
  name: conv_window_fetch

sources:
  # design, package first
  - files:
      - design/window_pkg.sv
      - design/frame_scanner.sv
      - design/bank_addresser.sv
      - design/pixel_slicer.sv
      - design/window_shifter.sv
      - design/conv_window_fetch.sv

  # testbench and bank model
  - target: test
    files:
      - tests/bank_memory.sv
      - tests/tb_conv_window_fetch.sv
